/* dcache_trace.txt */
// op (1 = store) size (0 byte, 1 half, 2 word) addr wdata
// hit (1 = no memory read expected) expected resp_data
0 2 00010040 00000000 0 fffe0040
0 2 00010040 00000000 1 fffe0040
0 0 00010046 00000000 1 000000fe
0 1 00010046 00000000 1 0000fffe
1 0 00010041 000000ab 1 00000000
1 1 00010046 00001234 1 00000000
0 2 00010040 00000000 1 fffeab40
0 2 00010044 00000000 1 12340044
1 2 000100c4 cafef00d 0 00000000
0 2 000100c4 00000000 1 cafef00d
0 2 000100c0 00000000 1 fffe00c0
0 2 00010040 00000000 1 fffeab40
1 0 00010203 0000005a 0 00000000
0 2 00010200 00000000 1 5afe0200
0 0 00010203 00000000 1 0000005a
0 2 00010140 00000000 0 fffe0140
0 2 000101c0 00000000 0 fffe01c0
0 2 00010240 00000000 0 fffe0240
0 2 000102c0 00000000 0 fffe02c0
0 2 00010340 00000000 0 fffe0340
0 2 000100c4 00000000 0 cafef00d
0 2 000100c0 00000000 1 fffe00c0
0 2 00010044 00000000 1 12340044
1 1 00010040 00007777 1 00000000
0 2 00010040 00000000 1 fffe7777
0 1 00010042 00000000 1 0000fffe

/* filelist.f */
dcache_pkg.sv
main_cache.sv
victim_cache.sv
miss_control.sv
dcache.sv
dcache_properties.sv
dcache_checker.sv
tb_dcache.sv

/* run.sh */
#!/bin/sh
# build and run the dcache testbench with Verilator, result taken from the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f filelist.f \
    --top-module tb_dcache -o sim_dcache > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_dcache > sim.log 2>&1
cat sim.log
grep -q "^Testbench passed$" sim.log && echo "run passed" || { echo "run failed"; exit 1; }

/* tb_dcache.sv */
`timescale 1ns/1ps

module tb_dcache;
    import dcache_pkg::*;

    localparam int max_reqs   = 64;
    localparam int trace_cols = 6;    // op, size, addr, wdata, hit, data

    logic            clock;
    logic            reset;
    logic            req_valid;
    logic            req_write;
    mem_size_t       req_size;
    logic [xlen-1:0] req_addr;
    logic [xlen-1:0] req_wdata;
    logic            busy;
    logic            resp_valid;
    logic [xlen-1:0] resp_data;
    logic            mem_read;
    logic [xlen-1:0] mem_read_addr;
    logic            mem_fill;
    block_t          mem_fill_data;
    logic            mem_write;
    logic [xlen-1:0] mem_write_addr;
    block_t          mem_write_data;

    int check_count;
    int error_count;
    int resp_count;

    logic [31:0] trace [max_reqs*trace_cols];
    logic [31:0] mem_words [logic [31:0]];   // only words written back are stored
    logic [15:0] lfsr;
    int          n_req;
    int          cycle_limit;
    int          cycles;
    logic        rd_pending;
    int          rd_wait;
    logic [31:0] rd_addr;

    dcache u_dcache (.*);

    dcache_checker u_checker (
        .clock, .reset,
        .req_valid, .req_write, .req_size, .req_addr, .req_wdata,
        .busy, .resp_valid, .resp_data, .mem_read, .mem_read_addr,
        .mem_write, .mem_write_addr, .mem_write_data,
        .check_count, .error_count, .resp_count
    );

    always #10 clock = ~clock;

    // untouched memory holds its own address with the upper half inverted
    function automatic logic [31:0] read_word(input logic [31:0] addr);
        if (mem_words.exists(addr)) begin
            return mem_words[addr];
        end
        return {~addr[31:16], addr[15:0]};
    endfunction

    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        logic [15:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 16'hb400;
        end
        return next;
    endfunction

    // memory model applies a write-back before it serves a read with random latency
    always @(negedge clock) begin
        logic [2:0] lat;
        lat = '0;
        if (mem_write) begin
            mem_words[{mem_write_addr[31:3], 3'b000}] = mem_write_data[31:0];
            mem_words[{mem_write_addr[31:3], 3'b100}] = mem_write_data[63:32];
        end
        mem_fill = 1'b0;
        if (rd_pending) begin
            if (rd_wait <= 1) begin
                mem_fill      = 1'b1;
                mem_fill_data = {read_word(rd_addr + 32'd4), read_word(rd_addr)};
                rd_pending    = 1'b0;
            end else begin
                rd_wait = rd_wait - 1;
            end
        end else if (mem_read) begin
            for (int k = 0; k < 3; k++) begin
                lat  = {lat[1:0], lfsr[0]};    // one step per bit
                lfsr = lfsr_step(lfsr);
            end
            rd_pending = 1'b1;
            rd_wait    = int'(lat) + 1;
            rd_addr    = mem_read_addr;
        end
    end

    always @(posedge clock) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout after %0d cycles, %0d of %0d responses seen",
                     cycles, resp_count, n_req);
            finish_run(1'b1);
        end
    end

    task automatic drive_request(input int idx);
        int base;
        base      = idx * trace_cols;
        req_valid = 1'b1;
        req_write = trace[base][0];
        req_size  = mem_size_t'(trace[base+1][1:0]);
        req_addr  = trace[base+2];
        req_wdata = trace[base+3];
    endtask

    task automatic finish_run(input logic timed_out);
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (!timed_out && error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    endtask

    initial begin
        int idx;
        clock         = 1'b0;
        reset         = 1'b1;
        req_valid     = 1'b0;
        req_write     = 1'b0;
        req_size      = size_word;
        req_addr      = '0;
        req_wdata     = '0;
        mem_fill      = 1'b0;
        mem_fill_data = '0;
        lfsr          = 16'd9292;
        rd_pending    = 1'b0;
        rd_wait       = 0;
        rd_addr       = '0;
        cycles        = 0;
        for (int i = 0; i < max_reqs*trace_cols; i++) begin
            trace[i] = 32'hffff_ffff;    // marks the end of the trace
        end
        $readmemh("dcache_trace.txt", trace);
        n_req = 0;
        while (n_req < max_reqs && trace[n_req*trace_cols] != 32'hffff_ffff) begin
            n_req = n_req + 1;
        end
        cycle_limit = n_req * 14 + 100;

        repeat (5) @(negedge clock);
        reset = 1'b0;

        idx = 0;
        while (idx < n_req) begin
            @(negedge clock);
            if (!busy) begin
                drive_request(idx);
                idx = idx + 1;
            end else begin
                req_valid = 1'b0;
            end
        end
        @(negedge clock);
        req_valid = 1'b0;
        while (resp_count < n_req) begin
            @(negedge clock);
        end
        repeat (10) @(negedge clock);    // room for a late write-back
        finish_run(1'b0);
    end

endmodule

/* dcache_checker.sv */
`timescale 1ns/1ps

module dcache_checker (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        req_valid,
    input  logic                        req_write,
    input  dcache_pkg::mem_size_t       req_size,
    input  logic [dcache_pkg::xlen-1:0] req_addr,
    input  logic [dcache_pkg::xlen-1:0] req_wdata,
    input  logic                        busy,
    input  logic                        resp_valid,
    input  logic [dcache_pkg::xlen-1:0] resp_data,
    input  logic                        mem_read,
    input  logic [dcache_pkg::xlen-1:0] mem_read_addr,
    input  logic                        mem_write,
    input  logic [dcache_pkg::xlen-1:0] mem_write_addr,
    input  dcache_pkg::block_t          mem_write_data,
    output int                          check_count,
    output int                          error_count,
    output int                          resp_count
);
    import dcache_pkg::*;

    localparam int max_reqs   = 64;
    localparam int trace_cols = 6;

    logic [31:0] trace [max_reqs*trace_cols];
    logic [31:0] arch_words [logic [31:0]];    // memory as the program sees it
    bit          dirty_blocks [logic [28:0]];  // blocks stored to since their last write-back
    logic        read_seen;
    logic [31:0] pending_addr;                 // address of the latest request
    int          req_count;

    initial begin
        for (int i = 0; i < max_reqs*trace_cols; i++) begin
            trace[i] = 32'hffff_ffff;
        end
        $readmemh("dcache_trace.txt", trace);
        check_count  = 0;
        error_count  = 0;
        resp_count   = 0;
        req_count    = 0;
        read_seen    = 1'b0;
        pending_addr = '0;
    end

    function automatic logic [31:0] arch_word(input logic [31:0] addr);
        if (arch_words.exists(addr)) begin
            return arch_words[addr];
        end
        return {~addr[31:16], addr[15:0]};
    endfunction

    // little-endian lane update within one word
    function automatic logic [31:0] merge_word(input logic [31:0] old, input mem_size_t size,
                                               input logic [1:0] lane, input logic [31:0] data);
        logic [31:0] result;
        result = old;
        if (size == size_byte) begin
            result[{lane, 3'b000} +: 8] = data[7:0];
        end else if (size == size_half) begin
            result[{lane[1], 4'b0000} +: 16] = data[15:0];
        end else begin
            result = data;
        end
        return result;
    endfunction

    always @(posedge clock) begin
        int          base;
        logic [31:0] waddr;
        logic [31:0] expect_lo;
        logic [31:0] expect_hi;
        logic [28:0] blk;
        if (!reset) begin
            if (busy && resp_count == req_count) begin
                $display("busy is high with no request pending");
                error_count = error_count + 1;
            end
            if (resp_valid) begin
                if (resp_count >= req_count) begin
                    $display("response arrived with no request pending");
                    error_count = error_count + 1;
                end else begin
                    base        = resp_count * trace_cols;
                    check_count = check_count + 2;
                    if (resp_data != trace[base+5]) begin
                        $display("FAILED resp_data: got %h, expected %h (request %0d)",
                                 resp_data, trace[base+5], resp_count);
                        error_count = error_count + 1;
                    end
                    if (!read_seen != trace[base+4][0]) begin
                        $display("FAILED hit: got %h, expected %h (request %0d)",
                                 !read_seen, trace[base+4][0], resp_count);
                        error_count = error_count + 1;
                    end
                end
                resp_count = resp_count + 1;
            end
            if (mem_read) begin
                read_seen = 1'b1;
                if (resp_count >= req_count) begin
                    $display("memory read issued with no request pending");
                    error_count = error_count + 1;
                end else begin
                    check_count = check_count + 1;
                    if (mem_read_addr != {pending_addr[31:3], 3'b000}) begin
                        $display("FAILED mem_read_addr: got %h, expected %h (request %0d)",
                                 mem_read_addr, {pending_addr[31:3], 3'b000}, resp_count);
                        error_count = error_count + 1;
                    end
                end
            end
            if (mem_write) begin
                waddr       = mem_write_addr;
                blk         = waddr[31:3];
                expect_lo   = arch_word({blk, 3'b000});
                expect_hi   = arch_word({blk, 3'b100});
                check_count = check_count + 1;
                if (!dirty_blocks.exists(blk) || !dirty_blocks[blk]) begin
                    $display("write-back of block at %h that holds no stored data", waddr);
                    error_count = error_count + 1;
                end else if (mem_write_data != {expect_hi, expect_lo}) begin
                    $display("FAILED mem_write_data: got %h, expected %h (address %h)",
                             mem_write_data, {expect_hi, expect_lo}, waddr);
                    error_count = error_count + 1;
                end
                dirty_blocks[blk] = 1'b0;
            end
            if (req_valid) begin
                read_seen    = 1'b0;
                pending_addr = req_addr;
                req_count    = req_count + 1;
                if (req_write) begin
                    waddr             = {req_addr[31:2], 2'b00};
                    arch_words[waddr] = merge_word(arch_word(waddr), req_size,
                                                   req_addr[1:0], req_wdata);
                    dirty_blocks[req_addr[31:3]] = 1'b1;
                end
            end
        end
    end

endmodule

/* dcache_properties.sv */
`timescale 1ns/1ps

module dcache_properties (
    input logic        clock,
    input logic        reset,
    input logic        req_valid,
    input logic        busy,
    input logic        resp_valid,
    input logic        mem_read,
    input logic        mem_write,
    input logic [31:0] mem_write_addr
);

    assert property (@(posedge clock) disable iff (reset) req_valid |-> !busy)
        else $error("request presented while the cache is busy");

    // busy mirrors the wait state
    assert property (@(posedge clock) disable iff (reset) mem_read |-> busy)
        else $error("memory read outside the wait state");

    assert property (@(posedge clock) disable iff (reset) !(resp_valid && mem_read))
        else $error("response and memory read in the same cycle");

    assert property (@(posedge clock) disable iff (reset)
                     mem_write |-> (mem_write_addr[2:0] == 3'b000))
        else $error("write-back address is not block aligned");

endmodule

bind dcache dcache_properties u_dcache_properties (
    .clock, .reset, .req_valid, .busy, .resp_valid,
    .mem_read, .mem_write, .mem_write_addr
);

/* dcache.sv */
`timescale 1ns/1ps

module dcache (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        req_valid,
    input  logic                        req_write,
    input  dcache_pkg::mem_size_t       req_size,
    input  logic [dcache_pkg::xlen-1:0] req_addr,
    input  logic [dcache_pkg::xlen-1:0] req_wdata,
    output logic                        busy,
    output logic                        resp_valid,
    output logic [dcache_pkg::xlen-1:0] resp_data,
    output logic                        mem_read,
    output logic [dcache_pkg::xlen-1:0] mem_read_addr,
    input  logic                        mem_fill,
    input  dcache_pkg::block_t          mem_fill_data,
    output logic                        mem_write,
    output logic [dcache_pkg::xlen-1:0] mem_write_addr,
    output dcache_pkg::block_t          mem_write_data
);
    import dcache_pkg::*;

    logic                   main_hit;
    block_t                 main_hit_data;
    logic                   vc_hit;
    block_t                 vc_hit_data;
    logic                   fill;
    logic [xlen-1:0]        fill_addr;
    block_t                 fill_data;
    logic                   fill_dirty;
    logic                   evict_valid;
    logic [vc_tag_bits-1:0] evict_addr;
    block_t                 evict_data;
    logic                   evict_dirty;

    main_cache u_main_cache (
        .clock, .reset,
        .req_valid, .req_write, .req_size, .req_addr, .req_wdata,
        .fill, .fill_addr, .fill_data, .fill_dirty,
        .main_hit, .main_hit_data,
        .evict_valid, .evict_addr, .evict_data, .evict_dirty
    );

    victim_cache u_victim_cache (
        .clock, .reset,
        .req_valid, .req_write, .req_size, .req_addr, .req_wdata,
        .evict_valid, .evict_addr, .evict_data, .evict_dirty,
        .vc_hit, .vc_hit_data,
        .mem_write, .mem_write_addr, .mem_write_data
    );

    miss_control u_miss_control (
        .clock, .reset,
        .req_valid, .req_write, .req_size, .req_addr, .req_wdata,
        .main_hit, .main_hit_data, .vc_hit, .vc_hit_data,
        .mem_fill, .mem_fill_data,
        .busy, .resp_valid, .resp_data,
        .mem_read, .mem_read_addr,
        .fill, .fill_addr, .fill_data, .fill_dirty
    );

endmodule

/* miss_control.sv */
`timescale 1ns/1ps

module miss_control (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        req_valid,
    input  logic                        req_write,
    input  dcache_pkg::mem_size_t       req_size,
    input  logic [dcache_pkg::xlen-1:0] req_addr,
    input  logic [dcache_pkg::xlen-1:0] req_wdata,
    input  logic                        main_hit,
    input  dcache_pkg::block_t          main_hit_data,
    input  logic                        vc_hit,
    input  dcache_pkg::block_t          vc_hit_data,
    input  logic                        mem_fill,
    input  dcache_pkg::block_t          mem_fill_data,
    output logic                        busy,
    output logic                        resp_valid,
    output logic [dcache_pkg::xlen-1:0] resp_data,
    output logic                        mem_read,
    output logic [dcache_pkg::xlen-1:0] mem_read_addr,
    output logic                        fill,
    output logic [dcache_pkg::xlen-1:0] fill_addr,
    output dcache_pkg::block_t          fill_data,
    output logic                        fill_dirty
);
    import dcache_pkg::*;

    typedef enum logic {
        st_ready,
        st_wait
    } state_t;

    state_t state;

    // request held while the block is fetched
    logic            saved_write;
    mem_size_t       saved_size;
    logic [xlen-1:0] saved_addr;
    logic [xlen-1:0] saved_wdata;

    logic   hit_resp;
    logic   miss;
    block_t hit_block;

    assign busy      = (state == st_wait);
    assign hit_resp  = (state == st_ready) && req_valid && (main_hit || vc_hit);
    assign miss      = (state == st_ready) && req_valid && !(main_hit || vc_hit);
    assign hit_block = main_hit ? main_hit_data : vc_hit_data;   // a block lives in one cache only

    // fill is formed in the cycle the memory block arrives
    assign fill       = (state == st_wait) && mem_fill;
    assign fill_addr  = {saved_addr[xlen-1:offset_bits], {offset_bits{1'b0}}};
    assign fill_dirty = saved_write;
    assign fill_data  = saved_write ? store_merge(mem_fill_data, saved_size,
                                                  saved_addr[offset_bits-1:0], saved_wdata)
                                    : mem_fill_data;

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= st_ready;
            resp_valid <= 1'b0;
            mem_read   <= 1'b0;
        end else begin
            resp_valid <= hit_resp || fill;
            mem_read   <= miss;            // single strobe, one read outstanding
            if (miss) begin
                state <= st_wait;
            end else if (fill) begin
                state <= st_ready;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (hit_resp) begin
            resp_data <= req_write ? '0
                                   : load_extract(hit_block, req_size, req_addr[offset_bits-1:0]);
        end else if (fill) begin
            resp_data <= saved_write ? '0
                                     : load_extract(fill_data, saved_size,
                                                    saved_addr[offset_bits-1:0]);
        end
        if (miss) begin
            saved_write   <= req_write;
            saved_size    <= req_size;
            saved_addr    <= req_addr;
            saved_wdata   <= req_wdata;
            mem_read_addr <= {req_addr[xlen-1:offset_bits], {offset_bits{1'b0}}};
        end
    end

endmodule

/* victim_cache.sv */
`timescale 1ns/1ps

module victim_cache (
    input  logic                               clock,
    input  logic                               reset,
    input  logic                               req_valid,
    input  logic                               req_write,
    input  dcache_pkg::mem_size_t              req_size,
    input  logic [dcache_pkg::xlen-1:0]        req_addr,
    input  logic [dcache_pkg::xlen-1:0]        req_wdata,
    input  logic                               evict_valid,
    input  logic [dcache_pkg::vc_tag_bits-1:0] evict_addr,
    input  dcache_pkg::block_t                 evict_data,
    input  logic                               evict_dirty,
    output logic                               vc_hit,
    output dcache_pkg::block_t                 vc_hit_data,
    output logic                               mem_write,
    output logic [dcache_pkg::xlen-1:0]        mem_write_addr,
    output dcache_pkg::block_t                 mem_write_data
);
    import dcache_pkg::*;

    typedef logic [$clog2(n_vc_lines)-1:0] vc_index_t;

    victim_line_t ents [n_vc_lines];

    logic [vc_tag_bits-1:0] req_btag;
    vc_index_t              hit_idx;
    logic                   has_free;
    vc_index_t              free_idx;
    vc_index_t              lru_idx;
    logic [lru_bits-1:0]    lru_min;
    vc_index_t              repl_idx;
    victim_line_t           repl_line;

    assign req_btag = req_addr[xlen-1:offset_bits];

    // fully associative compare, plus free slot and LRU search for the next eviction
    always_comb begin
        vc_hit   = 1'b0;
        hit_idx  = '0;
        has_free = 1'b0;
        free_idx = '0;
        lru_idx  = '0;
        lru_min  = ents[0].lru;
        for (int i = 0; i < n_vc_lines; i++) begin
            if (req_valid && ents[i].valid && ents[i].tag == req_btag) begin
                vc_hit  = 1'b1;
                hit_idx = vc_index_t'(i);
            end
            if (!ents[i].valid && !has_free) begin
                has_free = 1'b1;                 // first free entry wins
                free_idx = vc_index_t'(i);
            end
            if (ents[i].lru < lru_min) begin     // strict compare keeps the lowest index on a tie
                lru_min = ents[i].lru;
                lru_idx = vc_index_t'(i);
            end
        end
    end

    assign vc_hit_data = ents[hit_idx].block;
    assign repl_idx    = has_free ? free_idx : lru_idx;
    assign repl_line   = ents[repl_idx];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < n_vc_lines; i++) begin
                ents[i].valid <= 1'b0;
                ents[i].dirty <= 1'b0;
                ents[i].lru   <= '0;
            end
        end else if (evict_valid) begin
            ents[repl_idx] <= '{
                valid: 1'b1,
                dirty: evict_dirty,
                lru:   '0,
                tag:   evict_addr,
                block: evict_data
            };
        end else if (vc_hit) begin
            for (int i = 0; i < n_vc_lines; i++) begin
                if (vc_index_t'(i) == hit_idx) begin
                    ents[i].lru <= '1;              // most recent
                end else if (ents[i].lru != '0) begin
                    ents[i].lru <= ents[i].lru - 1'b1;
                end
            end
            if (req_write) begin
                ents[hit_idx].block <= store_merge(ents[hit_idx].block, req_size,
                                                   req_addr[offset_bits-1:0], req_wdata);
                ents[hit_idx].dirty <= 1'b1;
            end
        end
    end

    // a replaced entry goes to memory only when dirty, one cycle after the eviction
    always_ff @(posedge clock) begin
        if (reset) begin
            mem_write <= 1'b0;
        end else begin
            mem_write <= evict_valid && !has_free && repl_line.dirty;
        end
    end

    always_ff @(posedge clock) begin
        if (evict_valid) begin
            mem_write_addr <= {repl_line.tag, {offset_bits{1'b0}}};
            mem_write_data <= repl_line.block;
        end
    end

endmodule

/* main_cache.sv */
`timescale 1ns/1ps

module main_cache (
    input  logic                               clock,
    input  logic                               reset,
    input  logic                               req_valid,
    input  logic                               req_write,
    input  dcache_pkg::mem_size_t              req_size,
    input  logic [dcache_pkg::xlen-1:0]        req_addr,
    input  logic [dcache_pkg::xlen-1:0]        req_wdata,
    input  logic                               fill,
    input  logic [dcache_pkg::xlen-1:0]        fill_addr,
    input  dcache_pkg::block_t                 fill_data,
    input  logic                               fill_dirty,
    output logic                               main_hit,
    output dcache_pkg::block_t                 main_hit_data,
    output logic                               evict_valid,
    output logic [dcache_pkg::vc_tag_bits-1:0] evict_addr,
    output dcache_pkg::block_t                 evict_data,
    output logic                               evict_dirty
);
    import dcache_pkg::*;

    main_line_t lines [n_lines];

    logic [index_bits-1:0] req_index;
    logic [tag_bits-1:0]   req_tag;
    main_line_t            req_line;
    logic [index_bits-1:0] fill_index;
    main_line_t            old_line;

    assign req_index = req_addr[offset_bits +: index_bits];
    assign req_tag   = req_addr[xlen-1 -: tag_bits];
    assign req_line  = lines[req_index];

    assign main_hit      = req_valid && req_line.valid && (req_line.tag == req_tag);
    assign main_hit_data = req_line.block;

    // whatever sits at the fill index is pushed out to the victim cache
    assign fill_index  = fill_addr[offset_bits +: index_bits];
    assign old_line    = lines[fill_index];
    assign evict_valid = fill && old_line.valid;
    assign evict_addr  = {old_line.tag, fill_index};   // tag and index give the block address
    assign evict_data  = old_line.block;
    assign evict_dirty = old_line.dirty;

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < n_lines; i++) begin
                lines[i].valid <= 1'b0;
                lines[i].dirty <= 1'b0;
            end
        end else if (fill) begin
            lines[fill_index] <= '{
                valid: 1'b1,
                dirty: fill_dirty,
                tag:   fill_addr[xlen-1 -: tag_bits],
                block: fill_data
            };
        end else if (main_hit && req_write) begin
            // store hit, write the lanes in place
            lines[req_index].block <= store_merge(req_line.block, req_size,
                                                  req_addr[offset_bits-1:0], req_wdata);
            lines[req_index].dirty <= 1'b1;
        end
    end

endmodule

/* dcache_pkg.sv */
package dcache_pkg;

    localparam int xlen        = 32;
    localparam int block_bytes = 8;
    localparam int offset_bits = 3;
    localparam int n_lines     = 16;
    localparam int index_bits  = 4;
    localparam int tag_bits    = xlen - index_bits - offset_bits;   // 25
    localparam int n_vc_lines  = 4;
    localparam int vc_tag_bits = xlen - offset_bits;                // block address
    localparam int lru_bits    = 2;

    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } mem_size_t;

    typedef logic [block_bytes*8-1:0] block_t;

    typedef struct packed {
        logic                valid;
        logic                dirty;
        logic [tag_bits-1:0] tag;
        block_t              block;
    } main_line_t;

    typedef struct packed {
        logic                   valid;
        logic                   dirty;
        logic [lru_bits-1:0]    lru;
        logic [vc_tag_bits-1:0] tag;
        block_t                 block;
    } victim_line_t;

    // replace the lanes selected by size and offset, rest of the block unchanged
    function automatic block_t store_merge(
        input block_t                 blk,
        input mem_size_t              size,
        input logic [offset_bits-1:0] offset,
        input logic [xlen-1:0]        data
    );
        block_t merged;
        merged = blk;
        case (size)
            size_byte: merged[{offset, 3'b000} +: 8]        = data[7:0];
            size_half: merged[{offset[2:1], 4'b0000} +: 16] = data[15:0];
            default:   merged[{offset[2], 5'b00000} +: 32]  = data;
        endcase
        return merged;
    endfunction

    function automatic logic [xlen-1:0] load_extract(
        input block_t                 blk,
        input mem_size_t              size,
        input logic [offset_bits-1:0] offset
    );
        logic [xlen-1:0] value;
        case (size)
            size_byte: value = {24'b0, blk[{offset, 3'b000} +: 8]};          // zero-extended
            size_half: value = {16'b0, blk[{offset[2:1], 4'b0000} +: 16]};
            default:   value = blk[{offset[2], 5'b00000} +: 32];
        endcase
        return value;
    endfunction

endpackage
